// ==== hdl/igr_pb_mem_shell.sv ====
// bank array wrapper; a bank must never see a read and a write in one cycle
// o_bank_err bits are sticky and only reset clears them
`default_nettype none

module igr_pb_mem_shell #(
  parameter int PB_BANKS = 4,
  parameter int PB_DEPTH = 64
) (
  input  wire logic                                             cclk,
  input  wire logic                                             i_rst,
  input  wire logic [PB_BANKS-1:0]                              i_rd_bank_en,
  input  wire logic [$clog2(PB_DEPTH)-1:0]                      i_rd_row,
  input  wire logic [PB_BANKS-1:0]                              i_wr_bank_en,
  input  wire logic [$clog2(PB_DEPTH)-1:0]                      i_wr_row,
  input  wire logic [igr_pb_pkg::PB_DATA_W-1:0]                 i_wr_data,
  input  wire logic                                             i_wr_err_inj,
  output logic      [PB_BANKS-1:0][igr_pb_pkg::PB_DATA_W-1:0]   o_bank_rd_data,
  output logic      [PB_BANKS-1:0]                              o_bank_rd_valid,
  output logic      [PB_BANKS-1:0]                              o_bank_uerr,
  output logic                                                  o_init_done,
  output logic      [PB_BANKS-1:0]                              o_bank_err
);

  localparam int ROW_W = $clog2(PB_DEPTH);

  logic [PB_BANKS-1:0][ROW_W-1:0] bank_adr;
  logic [PB_BANKS-1:0]            bank_init_done;

  // ----------------------------------------------------------
  // one shell per bank
  // ----------------------------------------------------------
  for (genvar b = 0; b < PB_BANKS; b++) begin : gen_bank
    // the read row wins the shared address port when this bank is read
    assign bank_adr[b] = i_rd_bank_en[b] ? i_rd_row : i_wr_row;

    igr_pb_ram_shell #(
      .PB_DEPTH (PB_DEPTH)
    ) u_bank (
      .cclk            (cclk),
      .i_rst           (i_rst),
      .i_adr           (bank_adr[b]),
      .i_rd_en         (i_rd_bank_en[b]),
      .i_wr_en         (i_wr_bank_en[b]),
      .i_wr_err_inj    (i_wr_err_inj),
      .i_wr_data       (i_wr_data),
      .o_rd_data       (o_bank_rd_data[b]),
      .o_rd_valid      (o_bank_rd_valid[b]),
      .o_init_done     (bank_init_done[b]),
      .o_ecc_uncor_err (o_bank_uerr[b])
    );
  end

  // all banks sweep in lockstep, but wait for every one anyway
  assign o_init_done = &bank_init_done;

  // sticky per bank error status for software to poll
  always_ff @(posedge cclk) begin
    if (i_rst) begin
      o_bank_err <= '0;
    end else begin
      o_bank_err <= o_bank_err | o_bank_uerr;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/igr_pb_pkg.sv ====
// widths and latencies shared by the ingress packet buffer RTL and its testbench
// the parity scheme assumes the payload is a whole number of bytes
`default_nettype none

package igr_pb_pkg;

  // ----------------------------------------------------------
  // segment payload and stored word
  // ----------------------------------------------------------

  // one segment as it moves on the ingress and egress ports
  parameter int PB_DATA_W = 64;

  // one even parity bit covers each byte of the payload
  parameter int PB_PAR_W = PB_DATA_W / 8;

  // a bank row holds the parity bits above the payload
  parameter int PB_WORD_W = PB_DATA_W + PB_PAR_W;

  // ----------------------------------------------------------
  // read latencies
  // ----------------------------------------------------------

  // bank shell cycles from rd_en to rd_valid
  parameter int PB_RAM_LAT = 2;

  // top level cycles from i_rd_valid to o_rd_valid
  // the read controller adds one request register in front of the bank
  parameter int PB_RD_LAT = PB_RAM_LAT + 1;

endpackage

`default_nettype wire

// ==== hdl/igr_pb_ram_shell.sv ====
// behavioral single-port bank; PB_DEPTH must be a power of two
// reads and writes are ignored by the caller until o_init_done is high
`default_nettype none

module igr_pb_ram_shell #(
  parameter int PB_DEPTH = 64
) (
  input  wire logic                              cclk,
  input  wire logic                              i_rst,
  input  wire logic [$clog2(PB_DEPTH)-1:0]       i_adr,
  input  wire logic                              i_rd_en,
  input  wire logic                              i_wr_en,
  input  wire logic                              i_wr_err_inj,
  input  wire logic [igr_pb_pkg::PB_DATA_W-1:0]  i_wr_data,
  output logic      [igr_pb_pkg::PB_DATA_W-1:0]  o_rd_data,
  output logic                                   o_rd_valid,
  output logic                                   o_init_done,
  output logic                                   o_ecc_uncor_err
);

  localparam int ROW_W = $clog2(PB_DEPTH);
  localparam int DW    = igr_pb_pkg::PB_DATA_W;
  localparam int PW    = igr_pb_pkg::PB_PAR_W;

  // the generated shells reset on a low level, so the port is inverted here
  logic                               rst_n;
  logic [ROW_W-1:0]                   init_cnt;
  logic [PW-1:0]                      wr_par;
  logic [igr_pb_pkg::PB_WORD_W-1:0]   mem [PB_DEPTH];
  logic [igr_pb_pkg::PB_WORD_W-1:0]   rd_word_q;
  logic                               rd_vld_q;

  // even parity per byte, bit b covers payload byte b
  function automatic logic [PW-1:0] byte_par(input logic [DW-1:0] data);
    logic [PW-1:0] par;
    for (int b = 0; b < PW; b++) begin
      par[b] = ^data[8*b +: 8];
    end
    return par;
  endfunction

  assign rst_n = ~i_rst;

  // the error hook flips byte 0 parity so the next read of this row fails
  always_comb begin
    wr_par    = byte_par(i_wr_data);
    wr_par[0] = wr_par[0] ^ i_wr_err_inj;
  end

  // ----------------------------------------------------------
  // init sweep, one row per cycle after reset
  // ----------------------------------------------------------
  always_ff @(posedge cclk) begin
    if (!rst_n) begin
      init_cnt    <= '0;
      o_init_done <= 1'b0;
    end else if (!o_init_done) begin
      init_cnt <= init_cnt + 1'b1;
      // the last row is cleared on this edge
      if (init_cnt == ROW_W'(PB_DEPTH - 1)) begin
        o_init_done <= 1'b1;
      end
    end
  end

  // the sweep owns the port until it finishes
  // an all zero word carries good even parity, so zero is written as is
  always_ff @(posedge cclk) begin
    if (!o_init_done) begin
      mem[init_cnt] <= '0;
    end else if (i_wr_en) begin
      mem[i_adr] <= {wr_par, i_wr_data};
    end
  end

  // ----------------------------------------------------------
  // two stage read, parity checked in the second stage
  // ----------------------------------------------------------
  always_ff @(posedge cclk) begin
    if (i_rd_en) begin
      rd_word_q <= mem[i_adr];
    end
    o_rd_data <= rd_word_q[DW-1:0];
  end

  always_ff @(posedge cclk) begin
    if (!rst_n) begin
      rd_vld_q        <= 1'b0;
      o_rd_valid      <= 1'b0;
      o_ecc_uncor_err <= 1'b0;
    end else begin
      rd_vld_q        <= i_rd_en;
      o_rd_valid      <= rd_vld_q;
      // any byte mismatch is uncorrectable since there is no ECC here
      o_ecc_uncor_err <= rd_vld_q & (rd_word_q[DW +: PW] != byte_par(rd_word_q[DW-1:0]));
    end
  end

endmodule

`default_nettype wire

// ==== hdl/igr_pb_rd_ctrl.sv ====
// read steering with fixed latency; at most one request per cycle, no stalls
// requests before init is done return whatever the sweep has left
`default_nettype none

module igr_pb_rd_ctrl #(
  parameter int PB_BANKS = 4,
  parameter int PB_DEPTH = 64
) (
  input  wire logic                                             cclk,
  input  wire logic                                             i_rst,
  input  wire logic                                             i_rd_valid,
  input  wire logic [$clog2(PB_BANKS*PB_DEPTH)-1:0]             i_rd_seg,
  input  wire logic [PB_BANKS-1:0][igr_pb_pkg::PB_DATA_W-1:0]   i_bank_rd_data,
  input  wire logic [PB_BANKS-1:0]                              i_bank_rd_valid,
  input  wire logic [PB_BANKS-1:0]                              i_bank_uerr,
  output logic      [PB_BANKS-1:0]                              o_rd_bank_en,
  output logic      [$clog2(PB_DEPTH)-1:0]                      o_rd_row,
  output logic                                                  o_rd_valid,
  output logic      [igr_pb_pkg::PB_DATA_W-1:0]                 o_rd_data,
  output logic                                                  o_rd_err
);

  localparam int BANK_W = $clog2(PB_BANKS);
  localparam int LAT    = igr_pb_pkg::PB_RAM_LAT;

  logic              rd_vld_q;
  logic [BANK_W-1:0] rd_bank_q;
  logic [BANK_W-1:0] tag_pipe [LAT];
  logic [BANK_W-1:0] ret_bank;

  // ----------------------------------------------------------
  // request register, drives the bank port one cycle later
  // ----------------------------------------------------------
  always_ff @(posedge cclk) begin
    if (i_rst) begin
      rd_vld_q  <= 1'b0;
      rd_bank_q <= '0;
    end else begin
      rd_vld_q  <= i_rd_valid;
      rd_bank_q <= i_rd_seg[BANK_W-1:0];
    end
  end

  // the row is payload and only matters while the bank enable is set
  always_ff @(posedge cclk) begin
    o_rd_row <= i_rd_seg[$bits(i_rd_seg)-1:BANK_W];
  end

  // this vector is also the write side's busy mask
  assign o_rd_bank_en = rd_vld_q ? (PB_BANKS'(1) << rd_bank_q) : '0;

  // ----------------------------------------------------------
  // bank tag follows the read through the shell latency
  // ----------------------------------------------------------
  always_ff @(posedge cclk) begin
    if (i_rst) begin
      for (int s = 0; s < LAT; s++) begin
        tag_pipe[s] <= '0;
      end
    end else begin
      tag_pipe[0] <= rd_bank_q;
      for (int s = 1; s < LAT; s++) begin
        tag_pipe[s] <= tag_pipe[s-1];
      end
    end
  end

  assign ret_bank = tag_pipe[LAT-1];

  // only the tagged bank can be returning in this cycle
  assign o_rd_valid = i_bank_rd_valid[ret_bank];
  assign o_rd_data  = i_bank_rd_data[ret_bank];
  assign o_rd_err   = i_bank_uerr[ret_bank];

endmodule

`default_nettype wire

// ==== hdl/igr_pb_top.sv ====
// ingress packet buffer; PB_BANKS and PB_DEPTH must be powers of two, PB_BANKS >= 2
// writes need a credit and reads are legal only once o_init_done is high
`default_nettype none

module igr_pb_top #(
  parameter int PB_BANKS   = 4,
  parameter int PB_DEPTH   = 64,
  parameter int WR_CREDITS = 4
) (
  input  wire logic                                  cclk,
  input  wire logic                                  i_rst,
  input  wire logic                                  i_wr_valid,
  input  wire logic [igr_pb_pkg::PB_DATA_W-1:0]      i_wr_data,
  input  wire logic                                  i_wr_err_inj,
  output logic                                       o_wr_credit,
  input  wire logic                                  i_rd_valid,
  input  wire logic [$clog2(PB_BANKS*PB_DEPTH)-1:0]  i_rd_seg,
  output logic                                       o_rd_valid,
  output logic      [igr_pb_pkg::PB_DATA_W-1:0]      o_rd_data,
  output logic                                       o_rd_err,
  output logic                                       o_init_done,
  output logic      [PB_BANKS-1:0]                   o_bank_err
);

  localparam int ROW_W = $clog2(PB_DEPTH);

  // ----------------------------------------------------------
  // internal wiring between the controllers and the banks
  // ----------------------------------------------------------
  logic [PB_BANKS-1:0]                              rd_bank_en;
  logic [ROW_W-1:0]                                 rd_row;
  logic [PB_BANKS-1:0]                              wr_bank_en;
  logic [ROW_W-1:0]                                 wr_row;
  logic [igr_pb_pkg::PB_DATA_W-1:0]                 wr_data;
  logic                                             wr_err_inj;
  logic [PB_BANKS-1:0][igr_pb_pkg::PB_DATA_W-1:0]   bank_rd_data;
  logic [PB_BANKS-1:0]                              bank_rd_valid;
  logic [PB_BANKS-1:0]                              bank_uerr;

  // the write side sees the read enables as its busy mask
  igr_pb_wr_ctrl #(
    .PB_BANKS   (PB_BANKS),
    .PB_DEPTH   (PB_DEPTH),
    .WR_CREDITS (WR_CREDITS)
  ) u_wr_ctrl (
    .cclk           (cclk),
    .i_rst          (i_rst),
    .i_wr_valid     (i_wr_valid),
    .i_wr_data      (i_wr_data),
    .i_wr_err_inj   (i_wr_err_inj),
    .i_init_done    (o_init_done),
    .i_rd_bank_busy (rd_bank_en),
    .o_wr_credit    (o_wr_credit),
    .o_wr_bank_en   (wr_bank_en),
    .o_wr_row       (wr_row),
    .o_wr_data      (wr_data),
    .o_wr_err_inj   (wr_err_inj)
  );

  igr_pb_rd_ctrl #(
    .PB_BANKS (PB_BANKS),
    .PB_DEPTH (PB_DEPTH)
  ) u_rd_ctrl (
    .cclk            (cclk),
    .i_rst           (i_rst),
    .i_rd_valid      (i_rd_valid),
    .i_rd_seg        (i_rd_seg),
    .i_bank_rd_data  (bank_rd_data),
    .i_bank_rd_valid (bank_rd_valid),
    .i_bank_uerr     (bank_uerr),
    .o_rd_bank_en    (rd_bank_en),
    .o_rd_row        (rd_row),
    .o_rd_valid      (o_rd_valid),
    .o_rd_data       (o_rd_data),
    .o_rd_err        (o_rd_err)
  );

  igr_pb_mem_shell #(
    .PB_BANKS (PB_BANKS),
    .PB_DEPTH (PB_DEPTH)
  ) u_mem_shell (
    .cclk            (cclk),
    .i_rst           (i_rst),
    .i_rd_bank_en    (rd_bank_en),
    .i_rd_row        (rd_row),
    .i_wr_bank_en    (wr_bank_en),
    .i_wr_row        (wr_row),
    .i_wr_data       (wr_data),
    .i_wr_err_inj    (wr_err_inj),
    .o_bank_rd_data  (bank_rd_data),
    .o_bank_rd_valid (bank_rd_valid),
    .o_bank_uerr     (bank_uerr),
    .o_init_done     (o_init_done),
    .o_bank_err      (o_bank_err)
  );

endmodule

`default_nettype wire

// ==== hdl/igr_pb_wr_ctrl.sv ====
// write FIFO sized by WR_CREDITS; the sender must never push without a credit
// segment addresses are handed out in order and wrap, overwriting old data
`default_nettype none

module igr_pb_wr_ctrl #(
  parameter int PB_BANKS   = 4,
  parameter int PB_DEPTH   = 64,
  parameter int WR_CREDITS = 4
) (
  input  wire logic                              cclk,
  input  wire logic                              i_rst,
  input  wire logic                              i_wr_valid,
  input  wire logic [igr_pb_pkg::PB_DATA_W-1:0]  i_wr_data,
  input  wire logic                              i_wr_err_inj,
  input  wire logic                              i_init_done,
  input  wire logic [PB_BANKS-1:0]               i_rd_bank_busy,
  output logic                                   o_wr_credit,
  output logic      [PB_BANKS-1:0]               o_wr_bank_en,
  output logic      [$clog2(PB_DEPTH)-1:0]       o_wr_row,
  output logic      [igr_pb_pkg::PB_DATA_W-1:0]  o_wr_data,
  output logic                                   o_wr_err_inj
);

  localparam int BANK_W = $clog2(PB_BANKS);
  localparam int ROW_W  = $clog2(PB_DEPTH);
  localparam int SEG_W  = BANK_W + ROW_W;
  localparam int PTR_W  = (WR_CREDITS > 1) ? $clog2(WR_CREDITS) : 1;
  localparam int CNT_W  = $clog2(WR_CREDITS + 1);

  logic [igr_pb_pkg::PB_DATA_W-1:0] fifo_data [WR_CREDITS];
  logic                             fifo_inj  [WR_CREDITS];
  logic [PTR_W-1:0]                 wr_ptr;
  logic [PTR_W-1:0]                 rd_ptr;
  logic [CNT_W-1:0]                 fifo_cnt;
  logic [SEG_W-1:0]                 seg_cnt;
  logic [BANK_W-1:0]                head_bank;
  logic                             issue;

  // ----------------------------------------------------------
  // issue decision for the head entry
  // ----------------------------------------------------------

  // the next segment number decides the bank, low bits stripe across banks
  assign head_bank = seg_cnt[BANK_W-1:0];
  assign o_wr_row  = seg_cnt[SEG_W-1:BANK_W];

  // a read registered for the same bank this cycle owns its port
  assign issue = (fifo_cnt != '0) & i_init_done & ~i_rd_bank_busy[head_bank];

  assign o_wr_bank_en = issue ? (PB_BANKS'(1) << head_bank) : '0;
  assign o_wr_data    = fifo_data[rd_ptr];
  assign o_wr_err_inj = fifo_inj[rd_ptr];

  // each issued entry hands one credit back to the sender
  assign o_wr_credit = issue;

  // ----------------------------------------------------------
  // FIFO storage and pointers
  // ----------------------------------------------------------
  always_ff @(posedge cclk) begin
    if (i_wr_valid) begin
      fifo_data[wr_ptr] <= i_wr_data;
      fifo_inj[wr_ptr]  <= i_wr_err_inj;
    end
  end

  always_ff @(posedge cclk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
      seg_cnt  <= '0;
    end else begin
      if (i_wr_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(WR_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (issue) begin
        rd_ptr  <= (rd_ptr == PTR_W'(WR_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
        // the counter wraps past the last row, so the oldest segment is reused
        seg_cnt <= seg_cnt + 1'b1;
      end
      // credits bound the fill level, so no overflow check is kept
      case ({i_wr_valid, issue})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== igr_pb_top.f ====
hdl/igr_pb_pkg.sv
hdl/igr_pb_ram_shell.sv
hdl/igr_pb_mem_shell.sv
hdl/igr_pb_wr_ctrl.sv
hdl/igr_pb_rd_ctrl.sv
hdl/igr_pb_top.sv
tests/igr_pb_properties.sv
tests/igr_pb_tb.sv

// ==== tests/igr_pb_properties.sv ====
// checker bound into igr_pb_top; assumes reset is held for at least two cycles
`default_nettype none

module igr_pb_properties (
  input wire logic cclk,
  input wire logic i_rst,
  input wire logic i_wr_valid,
  input wire logic o_wr_credit,
  input wire logic i_rd_valid,
  input wire logic o_rd_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // writes accepted minus credits handed back
  int outstanding;

  always_ff @(posedge cclk) begin
    if (i_rst) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(i_wr_valid) - int'(o_wr_credit);
    end
  end

  // ----------------------------------------------------------
  // read latency is fixed in both directions
  // ----------------------------------------------------------
  rd_latency_a: assert property (@(posedge cclk) disable iff (i_rst)
    i_rd_valid |-> ##(igr_pb_pkg::PB_RD_LAT) o_rd_valid)
    else $error("read request produced no data after the fixed latency");

  rd_no_spurious_a: assert property (@(posedge cclk) disable iff (i_rst)
    o_rd_valid |-> $past(i_rd_valid, igr_pb_pkg::PB_RD_LAT))
    else $error("read data returned without a matching request");

  // ----------------------------------------------------------
  // credits and reset
  // ----------------------------------------------------------
  credit_bound_a: assert property (@(posedge cclk) disable iff (i_rst)
    o_wr_credit |-> outstanding > 0)
    else $error("credit returned with no write held in the FIFO");

  // the first reset edge clears the registers, so check from the second one on
  rst_quiet_a: assert property (@(posedge cclk)
    (i_rst ##1 i_rst) |-> (!o_wr_credit && !o_rd_valid))
    else $error("credit or read valid active during reset");

endmodule

`default_nettype wire

// ==== tests/igr_pb_tb.sv ====
// self-checking testbench with the default top level parameters
// reads only target segments whose writes have drained, so the shadow is exact
`default_nettype none

module igr_pb_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PB_BANKS   = 4;
  localparam int PB_DEPTH   = 64;
  localparam int WR_CREDITS = 4;
  localparam int N_SEG      = PB_BANKS * PB_DEPTH;
  localparam int SEG_W      = $clog2(N_SEG);
  localparam int DW         = igr_pb_pkg::PB_DATA_W;
  localparam int LAT        = igr_pb_pkg::PB_RD_LAT;
  // operation counts per test, the watchdog budget is built from them
  localparam int T2_WR      = 64;
  localparam int T3_RD      = 32;
  localparam int T3_WR      = 16;
  localparam int T5_WR      = N_SEG + 20;
  localparam int N_OPS      = N_SEG + 2 * T2_WR + T3_RD + 2 * T3_WR + 2 + T5_WR + N_SEG;
  localparam int WD_CYCLES  = 5 + PB_DEPTH + 4 * N_OPS;

  logic                cclk = 1'b0;
  logic                i_rst;
  logic                i_wr_valid;
  logic [DW-1:0]       i_wr_data;
  logic                i_wr_err_inj;
  logic                o_wr_credit;
  logic                i_rd_valid;
  logic [SEG_W-1:0]    i_rd_seg;
  logic                o_rd_valid;
  logic [DW-1:0]       o_rd_data;
  logic                o_rd_err;
  logic                o_init_done;
  logic [PB_BANKS-1:0] o_bank_err;

  // shadow copy of every segment, indexed like the DUT's segment number
  logic [DW-1:0] shadow_data [N_SEG];
  logic          shadow_inj  [N_SEG];
  int            wr_seg;
  int            credits;
  int            cyc = 0;
  int            init_cyc;
  int            n_checks;
  int            n_errors;
  int            seg;
  logic [DW-1:0] rnd;

  // expected results in request order
  logic [DW-1:0] exp_data [$];
  logic          exp_err  [$];
  int            exp_seg  [$];
  int            exp_cyc  [$];
  logic [DW-1:0] chk_data;
  logic          chk_err;
  int            chk_seg;
  int            chk_cyc;

  igr_pb_top dut_i (
    .cclk         (cclk),
    .i_rst        (i_rst),
    .i_wr_valid   (i_wr_valid),
    .i_wr_data    (i_wr_data),
    .i_wr_err_inj (i_wr_err_inj),
    .o_wr_credit  (o_wr_credit),
    .i_rd_valid   (i_rd_valid),
    .i_rd_seg     (i_rd_seg),
    .o_rd_valid   (o_rd_valid),
    .o_rd_data    (o_rd_data),
    .o_rd_err     (o_rd_err),
    .o_init_done  (o_init_done),
    .o_bank_err   (o_bank_err)
  );

  bind igr_pb_top igr_pb_properties props_i (
    .cclk        (cclk),
    .i_rst       (i_rst),
    .i_wr_valid  (i_wr_valid),
    .o_wr_credit (o_wr_credit),
    .i_rd_valid  (i_rd_valid),
    .o_rd_valid  (o_rd_valid)
  );

  always #50 cclk = ~cclk;

  always @(posedge cclk) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------------------------
  // stimulus helpers, inputs change 10 ns after the rising edge
  // ----------------------------------------------------------
  task automatic tick();
    @(posedge cclk);
    #10;
  endtask

  // expected read is the last word written to the segment, error if injected
  function automatic logic [DW:0] expected_read(input int s);
    return {shadow_inj[s], shadow_data[s]};
  endfunction

  // segment numbers follow push order since the FIFO issues in order
  task automatic write_seg(input logic [DW-1:0] data, input logic inj);
    while (credits == 0) begin
      tick();
    end
    i_wr_valid   = 1'b1;
    i_wr_data    = data;
    i_wr_err_inj = inj;
    shadow_data[wr_seg] = data;
    shadow_inj[wr_seg]  = inj;
    wr_seg  = (wr_seg + 1) % N_SEG;
    credits = credits - 1;
    tick();
    i_wr_valid   = 1'b0;
    i_wr_err_inj = 1'b0;
  endtask

  task automatic read_seg(input int s);
    logic [DW:0] word;
    word = expected_read(s);
    i_rd_valid = 1'b1;
    i_rd_seg   = SEG_W'(s);
    exp_data.push_back(word[DW-1:0]);
    exp_err.push_back(word[DW]);
    exp_seg.push_back(s);
    exp_cyc.push_back(cyc);
    tick();
    i_rd_valid = 1'b0;
  endtask

  task automatic drain_writes();
    while (credits != WR_CREDITS) begin
      tick();
    end
  endtask

  task automatic wait_reads();
    while (exp_seg.size() != 0) begin
      tick();
    end
  endtask

  task automatic check_bank_err(input logic [PB_BANKS-1:0] want);
    n_checks++;
    if (o_bank_err !== want) begin
      n_errors++;
      $display("ERROR o_bank_err: got 0x%h, expected 0x%h", o_bank_err, want);
    end
  endtask

  // ----------------------------------------------------------
  // checker, samples on the falling edge where outputs are settled
  // ----------------------------------------------------------
  always @(negedge cclk) begin
    if (o_wr_credit === 1'b1) begin
      credits = credits + 1;
      if (credits > WR_CREDITS) begin
        n_errors++;
        $display("a credit came back with no write outstanding");
      end
    end
    if (o_rd_valid === 1'b1) begin
      if (exp_seg.size() == 0) begin
        n_errors++;
        $display("read data came back with no read outstanding");
      end else begin
        chk_data = exp_data.pop_front();
        chk_err  = exp_err.pop_front();
        chk_seg  = exp_seg.pop_front();
        chk_cyc  = exp_cyc.pop_front();
        n_checks++;
        if (o_rd_data !== chk_data) begin
          n_errors++;
          $display("ERROR o_rd_data seg 0x%h: got 0x%h, expected 0x%h",
                   chk_seg, o_rd_data, chk_data);
        end
        if (o_rd_err !== chk_err) begin
          n_errors++;
          $display("ERROR o_rd_err seg 0x%h: got 0x%h, expected 0x%h",
                   chk_seg, o_rd_err, chk_err);
        end
        if (cyc - chk_cyc != LAT) begin
          n_errors++;
          $display("read of segment %0d returned %0d cycles after its request, not %0d",
                   chk_seg, cyc - chk_cyc, LAT);
        end
      end
    end
    // a request older than the latency that never returned is dropped here
    if (exp_cyc.size() != 0 && cyc - exp_cyc[0] > LAT) begin
      n_errors++;
      $display("read of segment %0d never returned its data", exp_seg[0]);
      void'(exp_data.pop_front());
      void'(exp_err.pop_front());
      void'(exp_seg.pop_front());
      void'(exp_cyc.pop_front());
    end
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'h09a0_fe7c));
    i_rst        = 1'b1;
    i_wr_valid   = 1'b0;
    i_wr_data    = '0;
    i_wr_err_inj = 1'b0;
    i_rd_valid   = 1'b0;
    i_rd_seg     = '0;
    wr_seg       = 0;
    credits      = WR_CREDITS;
    n_checks     = 0;
    n_errors     = 0;
    for (int s = 0; s < N_SEG; s++) begin
      shadow_data[s] = '0;
      shadow_inj[s]  = 1'b0;
    end
    repeat (5) @(posedge cclk);
    #10;
    i_rst    = 1'b0;
    init_cyc = cyc;

    // status outputs leave reset low
    n_checks++;
    if (o_init_done !== 1'b0) begin
      n_errors++;
      $display("ERROR o_init_done: got 0x%h, expected 0x0", o_init_done);
    end
    n_checks++;
    if (o_rd_err !== 1'b0) begin
      n_errors++;
      $display("ERROR o_rd_err: got 0x%h, expected 0x0", o_rd_err);
    end
    check_bank_err('0);

    // the sweep clears one row per cycle in every bank at once
    while (!o_init_done) begin
      tick();
    end
    n_checks++;
    if (cyc - init_cyc != PB_DEPTH) begin
      n_errors++;
      $display("o_init_done rose %0d cycles after reset release, not %0d",
               cyc - init_cyc, PB_DEPTH);
    end

    // init sweep leaves every segment zero with good parity
    for (int s = 0; s < N_SEG; s++) begin
      read_seg(s);
    end
    wait_reads();
    check_bank_err('0);

    // random data striped over all banks, read back in random order
    for (int i = 0; i < T2_WR; i++) begin
      write_seg({$urandom, $urandom}, 1'b0);
    end
    drain_writes();
    for (int i = 0; i < T2_WR; i++) begin
      read_seg($urandom_range(T2_WR - 1, 0));
    end
    wait_reads();

    // reads every cycle push the pending writes aside
    fork
      for (int i = 0; i < T3_WR; i++) begin
        write_seg({$urandom, $urandom}, 1'b0);
      end
      for (int j = 0; j < T3_RD; j++) begin
        read_seg($urandom_range(T2_WR - 1, 0));
      end
    join
    drain_writes();
    for (int i = 0; i < T3_WR; i++) begin
      read_seg(T2_WR + i);
    end
    wait_reads();

    // injected parity error flags the read and sets only that bank's bit
    seg = wr_seg;
    rnd = {$urandom, $urandom};
    write_seg(rnd, 1'b1);
    drain_writes();
    read_seg(seg);
    wait_reads();
    check_bank_err(PB_BANKS'(1) << (seg % PB_BANKS));

    // more writes than rows wrap around, newest data wins
    for (int i = 0; i < T5_WR; i++) begin
      write_seg({$urandom, $urandom}, 1'b0);
    end
    drain_writes();
    for (int s = 0; s < N_SEG; s++) begin
      read_seg(s);
    end
    wait_reads();
    // the error bit is sticky even after the row was rewritten
    check_bank_err(PB_BANKS'(1) << (seg % PB_BANKS));

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog sized from the total number of reads and writes
  initial begin
    repeat (WD_CYCLES) @(posedge cclk);
    $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
